// File: src.f
src/rs_gf_pkg.sv
src/rs_syn_pkg.sv
src/beat_decode.sv
src/syndrome_accum.sv
src/syndrome_report.sv
src/rs_syndrome_top.sv
verif/syn_checker.sv
verif/tb_rs_syndrome.sv

// File: Bender.yml
package:
  name: rs_syndrome

sources:
  - src/rs_gf_pkg.sv
  - src/rs_syn_pkg.sv
  - src/beat_decode.sv
  - src/syndrome_accum.sv
  - src/syndrome_report.sv
  - src/rs_syndrome_top.sv
  - target: test
    files:
      - verif/syn_checker.sv
      - verif/tb_rs_syndrome.sv

// File: verif/tb_rs_syndrome.sv
`timescale 1ns/1ps

module tb_rs_syndrome;

    import rs_gf_pkg::*;
    import rs_syn_pkg::*;

    localparam int NUM_SYN   = DEF_NUM_SYN;
    localparam int SPB       = DEF_SYMS_PER_BEAT;
    localparam int MAX_BEATS = 6;
    localparam int HOLD_IDLE = 20;

    // codewords per test
    localparam int N_RANDOM = 40;
    localparam int N_ZERO   = 10;
    localparam int N_SINGLE = 20;
    localparam int N_GATED  = 30;
    localparam int N_B2B    = 30;
    localparam int N_PULSE  = 20;
    localparam int TOTAL_CW = N_RANDOM + N_ZERO + N_SINGLE + N_GATED + N_B2B + N_PULSE;

    // each beat may be preceded by one gap cycle, plus drain per test
    localparam int PLANNED = 8 + TOTAL_CW * MAX_BEATS * 2 + 6 * 8 + HOLD_IDLE;
    localparam int LIMIT   = 2 * PLANNED + 100;

    logic                     clk;
    logic                     rstn;
    logic                     rs_ena;
    logic                     data_vld;
    logic                     data_init;
    logic                     data_last;
    beat_t                    syn_data;
    logic [NUM_SYN*SYM_W-1:0] rs_syn;
    logic                     syn_error;
    logic                     syn_nerror;
    logic                     syn_done;

    int     err_count;
    int     pending;
    int     done_count;
    int     top_err;
    int     err_base;
    int     done_base;
    int     cycles;
    integer seed;

    rs_syndrome_top #(
        .NUM_SYN       (NUM_SYN),
        .SYMS_PER_BEAT (SPB)
    ) uut (
        .clk        (clk),
        .rstn       (rstn),
        .rs_ena     (rs_ena),
        .data_vld   (data_vld),
        .data_init  (data_init),
        .data_last  (data_last),
        .syn_data   (syn_data),
        .rs_syn     (rs_syn),
        .syn_error  (syn_error),
        .syn_nerror (syn_nerror),
        .syn_done   (syn_done)
    );

    syn_checker #(
        .NUM_SYN       (NUM_SYN),
        .SYMS_PER_BEAT (SPB)
    ) chk (
        .clk        (clk),
        .rstn       (rstn),
        .rs_ena     (rs_ena),
        .data_vld   (data_vld),
        .data_init  (data_init),
        .data_last  (data_last),
        .syn_data   (syn_data),
        .rs_syn     (rs_syn),
        .syn_error  (syn_error),
        .syn_nerror (syn_nerror),
        .syn_done   (syn_done),
        .err_count  (err_count),
        .pending    (pending),
        .done_count (done_count)
    );

    always #4 clk = ~clk;

    function automatic beat_t rand_beat();
        beat_t b;
        b = {$random(seed), $random(seed)};
        return b;
    endfunction

    function automatic int rand_len(input int max_len);
        return 1 + ($unsigned($random(seed)) % max_len);
    endfunction

    task automatic drive(input logic ena, input logic vld, input logic init,
                         input logic last, input beat_t data);
        @(posedge clk);
        #1;
        rs_ena    = ena;
        data_vld  = vld;
        data_init = init;
        data_last = last;
        syn_data  = data;
    endtask

    // idle cycle, or a gated one carrying junk when allowed
    task automatic insert_gap(input bit gated);
        int r;
        r = $random(seed) & 3;
        if (r == 0) begin
            drive(1'b1, 1'b0, $random(seed), $random(seed), rand_beat());
        end else if (r == 1 && gated) begin
            drive(1'b0, 1'b1, $random(seed), $random(seed), rand_beat());
        end
    endtask

    task automatic send_codeword(input int nbeats, input bit zero, input bit gaps,
                                 input bit gated);
        for (int b = 0; b < nbeats; b++) begin
            if (gaps) begin
                insert_gap(gated);
            end
            drive(1'b1, 1'b1, b == 0, b == nbeats - 1, zero ? beat_t'(0) : rand_beat());
        end
    endtask

    task automatic start_test();
        err_base  = err_count + top_err;
        done_base = done_count;
    endtask

    // drain the pipeline, then report this test
    task automatic finish_test(input string name, input int n_cw);
        drive(1'b1, 1'b0, 1'b0, 1'b0, '0);
        @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
        if (done_count - done_base != n_cw) begin
            $display("%s: %0d syn_done pulses seen for %0d codewords",
                     name, done_count - done_base, n_cw);
            top_err++;
        end
        $display("%-14s errors: %0d", name, err_count + top_err - err_base);
    endtask

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d cycles", LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed      = 61;
        top_err   = 0;
        clk       = 1'b0;
        rstn      = 1'b0;
        rs_ena    = 1'b0;
        data_vld  = 1'b0;
        data_init = 1'b0;
        data_last = 1'b0;
        syn_data  = '0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        start_test();
        for (int i = 0; i < N_RANDOM; i++) begin
            send_codeword(rand_len(MAX_BEATS), 1'b0, 1'b1, 1'b0);
        end
        finish_test("random_cw", N_RANDOM);

        // clean codewords must report no error
        start_test();
        for (int i = 0; i < N_ZERO; i++) begin
            send_codeword(rand_len(MAX_BEATS), 1'b1, 1'b1, 1'b0);
        end
        finish_test("zero_cw", N_ZERO);

        start_test();
        for (int i = 0; i < N_SINGLE; i++) begin
            send_codeword(1, 1'b0, 1'b1, 1'b0);
        end
        finish_test("single_beat", N_SINGLE);

        start_test();
        for (int i = 0; i < N_GATED; i++) begin
            send_codeword(rand_len(MAX_BEATS), 1'b0, 1'b1, 1'b1);
        end
        finish_test("gated_beats", N_GATED);

        start_test();
        for (int i = 0; i < N_B2B; i++) begin
            send_codeword(rand_len(3), 1'b0, 1'b0, 1'b0);
        end
        finish_test("back_to_back", N_B2B);

        // dense done pulses, then a quiet stretch where rs_syn must hold
        start_test();
        for (int i = 0; i < N_PULSE; i++) begin
            send_codeword(1, i % 3 == 0, 1'b0, 1'b0);
        end
        repeat (HOLD_IDLE) drive(1'b1, 1'b0, 1'b0, 1'b0, rand_beat());
        finish_test("flag_pulses", N_PULSE);

        $display("tests: 6  codewords: %0d  done: %0d  errors: %0d",
                 TOTAL_CW, done_count, err_count + top_err);
        if (err_count + top_err == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/syn_checker.sv
`timescale 1ns/1ps

module syn_checker #(
    parameter int NUM_SYN       = rs_syn_pkg::DEF_NUM_SYN,
    parameter int SYMS_PER_BEAT = rs_syn_pkg::DEF_SYMS_PER_BEAT
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                rs_ena,
    input  logic                                data_vld,
    input  logic                                data_init,
    input  logic                                data_last,
    input  rs_syn_pkg::beat_t                   syn_data,
    input  logic [NUM_SYN*rs_gf_pkg::SYM_W-1:0] rs_syn,
    input  logic                                syn_error,
    input  logic                                syn_nerror,
    input  logic                                syn_done,
    output int                                  err_count,
    output int                                  pending,
    output int                                  done_count
);

    import rs_gf_pkg::*;

    localparam int SET_W = NUM_SYN * SYM_W;

    sym_t             run  [NUM_SYN];
    sym_t             apow [NUM_SYN];
    sym_t             s;
    logic [SET_W-1:0] nxt;
    logic [SET_W-1:0] expv;
    logic [SET_W-1:0] held;
    logic [SET_W-1:0] exp_q [$];

    // carry-less product, reduced whenever bit 8 appears
    function automatic sym_t field_mul(input sym_t a, input sym_t b);
        logic [SYM_W:0] t;
        sym_t           p;
        p = '0;
        t = {1'b0, a};
        for (int i = 0; i < SYM_W; i++) begin
            if (b[i]) begin
                p = p ^ t[SYM_W-1:0];
            end
            t = t << 1;
            if (t[SYM_W]) begin
                t = t ^ GF_POLY;
            end
        end
        return p;
    endfunction

    // evaluation points alpha^j
    initial begin
        err_count  = 0;
        done_count = 0;
        pending    = 0;
        apow[0]    = 8'h01;
        for (int j = 1; j < NUM_SYN; j++) begin
            apow[j] = field_mul(apow[j-1], 8'h02);
        end
    end

    // everything is stable at the falling edge
    always @(negedge clk) begin
        if (!rstn) begin
            for (int j = 0; j < NUM_SYN; j++) begin
                run[j] = '0;
            end
            exp_q.delete();
            held = '0;
        end else begin
            if (syn_done) begin
                done_count++;
                if (exp_q.size() == 0) begin
                    $display("syn_done raised while no codeword was pending");
                    err_count++;
                end else begin
                    expv = exp_q.pop_front();
                    if (rs_syn !== expv) begin
                        $display("ERR rs_syn: got %h expected %h", rs_syn, expv);
                        err_count++;
                    end
                    if (syn_error !== (expv != '0)) begin
                        $display("ERR syn_error: got %h expected %h", syn_error, expv != '0);
                        err_count++;
                    end
                    if (syn_nerror !== (expv == '0)) begin
                        $display("ERR syn_nerror: got %h expected %h",
                                 syn_nerror, expv == '0);
                        err_count++;
                    end
                end
                held = rs_syn;
            end else begin
                if (syn_error || syn_nerror) begin
                    $display("syn_error or syn_nerror pulsed without syn_done");
                    err_count++;
                end
                if (rs_syn !== held) begin
                    $display("ERR rs_syn: changed between done pulses, got %h held %h",
                             rs_syn, held);
                    err_count++;
                end
            end
            if (syn_error && syn_nerror) begin
                $display("syn_error and syn_nerror were high in the same cycle");
                err_count++;
            end

            // symbol by symbol Horner, byte 7 enters first
            if (rs_ena && data_vld) begin
                for (int j = 0; j < NUM_SYN; j++) begin
                    s = data_init ? sym_t'(0) : run[j];
                    for (int k = SYMS_PER_BEAT - 1; k >= 0; k--) begin
                        s = field_mul(s, apow[j]) ^ syn_data[k*SYM_W +: SYM_W];
                    end
                    run[j] = s;
                    nxt[j*SYM_W +: SYM_W] = s;
                end
                if (data_last) begin
                    exp_q.push_back(nxt);
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

// File: src/rs_syndrome_top.sv
`timescale 1ns/1ps

module rs_syndrome_top #(
    parameter int NUM_SYN       = rs_syn_pkg::DEF_NUM_SYN,
    parameter int SYMS_PER_BEAT = rs_syn_pkg::DEF_SYMS_PER_BEAT
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                rs_ena,
    input  logic                                data_vld,
    input  logic                                data_init,
    input  logic                                data_last,
    input  rs_syn_pkg::beat_t                   syn_data,
    output logic [NUM_SYN*rs_gf_pkg::SYM_W-1:0] rs_syn,
    output logic                                syn_error,
    output logic                                syn_nerror,
    output logic                                syn_done
);

    import rs_gf_pkg::*;
    import rs_syn_pkg::*;

    // decode to accumulate
    logic  beat_take;
    logic  beat_first;
    logic  beat_last;
    beat_t beat_data;

    // accumulate to report
    logic                     syn_close;
    logic [NUM_SYN*SYM_W-1:0] syn_final;

    beat_decode u_decode (
        .clk        (clk),
        .rstn       (rstn),
        .rs_ena     (rs_ena),
        .data_vld   (data_vld),
        .data_init  (data_init),
        .data_last  (data_last),
        .syn_data   (syn_data),
        .beat_take  (beat_take),
        .beat_first (beat_first),
        .beat_last  (beat_last),
        .beat_data  (beat_data)
    );

    syndrome_accum #(
        .NUM_SYN       (NUM_SYN),
        .SYMS_PER_BEAT (SYMS_PER_BEAT)
    ) u_accum (
        .clk        (clk),
        .rstn       (rstn),
        .beat_take  (beat_take),
        .beat_first (beat_first),
        .beat_last  (beat_last),
        .beat_data  (beat_data),
        .syn_close  (syn_close),
        .syn_final  (syn_final)
    );

    syndrome_report #(
        .NUM_SYN (NUM_SYN)
    ) u_report (
        .clk        (clk),
        .rstn       (rstn),
        .syn_close  (syn_close),
        .syn_final  (syn_final),
        .rs_syn     (rs_syn),
        .syn_error  (syn_error),
        .syn_nerror (syn_nerror),
        .syn_done   (syn_done)
    );

endmodule

// File: src/syndrome_report.sv
`timescale 1ns/1ps

module syndrome_report #(
    parameter int NUM_SYN = rs_syn_pkg::DEF_NUM_SYN
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                syn_close,
    input  logic [NUM_SYN*rs_gf_pkg::SYM_W-1:0] syn_final,
    output logic [NUM_SYN*rs_gf_pkg::SYM_W-1:0] rs_syn,
    output logic                                syn_error,
    output logic                                syn_nerror,
    output logic                                syn_done
);

    import rs_gf_pkg::*;

    localparam int SET_W = NUM_SYN * SYM_W;

    logic any_nz;

    // a single nonzero syndrome means the codeword is corrupted
    assign any_nz = |syn_final[SET_W-1:0];

    // final set stays on the outputs until the next codeword closes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rs_syn <= '0;
        end else if (syn_close) begin
            rs_syn <= syn_final;
        end
    end

    // one-cycle flags, exactly one of error/nerror with each done
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            syn_error  <= 1'b0;
            syn_nerror <= 1'b0;
            syn_done   <= 1'b0;
        end else begin
            syn_error  <= syn_close & any_nz;
            syn_nerror <= syn_close & ~any_nz;
            syn_done   <= syn_close;
        end
    end

endmodule

// File: src/syndrome_accum.sv
`timescale 1ns/1ps

module syndrome_accum #(
    parameter int NUM_SYN       = rs_syn_pkg::DEF_NUM_SYN,
    parameter int SYMS_PER_BEAT = rs_syn_pkg::DEF_SYMS_PER_BEAT
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                beat_take,
    input  logic                                beat_first,
    input  logic                                beat_last,
    input  rs_syn_pkg::beat_t                   beat_data,
    output logic                                syn_close,
    output logic [NUM_SYN*rs_gf_pkg::SYM_W-1:0] syn_final
);

    import rs_gf_pkg::*;

    localparam int SET_W = NUM_SYN * SYM_W;

    sym_t             syms [SYMS_PER_BEAT];
    logic [SET_W-1:0] syn_q;
    logic [SET_W-1:0] syn_next;

    // byte 0 is the latest symbol, so it carries weight alpha^0
    for (genvar k = 0; k < SYMS_PER_BEAT; k++) begin : g_sym
        assign syms[k] = beat_data[k*SYM_W +: SYM_W];
    end

    for (genvar j = 0; j < NUM_SYN; j++) begin : g_syn
        // shift of a whole beat for syndrome j
        localparam sym_t STEP = gf_alpha_pow(j * SYMS_PER_BEAT);

        sym_t term [SYMS_PER_BEAT];
        sym_t wsum;
        sym_t carried;

        for (genvar k = 0; k < SYMS_PER_BEAT; k++) begin : g_term
            localparam sym_t COEF = gf_alpha_pow(j * k);
            assign term[k] = gf_mul(syms[k], COEF);
        end

        // weighted sum of this beat
        always_comb begin
            sym_t acc;
            acc = '0;
            for (int k = 0; k < SYMS_PER_BEAT; k++) begin
                acc = acc ^ term[k];
            end
            wsum = acc;
        end

        // Horner step over the previous beats
        assign carried = gf_mul(syn_q[j*SYM_W +: SYM_W], STEP);

        // a first beat drops whatever was running before it
        assign syn_next[j*SYM_W +: SYM_W] = beat_first ? wsum : (carried ^ wsum);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            syn_q <= '0;
        end else if (beat_take) begin
            syn_q <= syn_next;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            syn_close <= 1'b0;
        end else begin
            syn_close <= beat_take & beat_last;
        end
    end

    // completed set, only looked at while syn_close is high
    always_ff @(posedge clk) begin
        if (beat_take && beat_last) begin
            syn_final <= syn_next;
        end
    end

endmodule

// File: src/beat_decode.sv
`timescale 1ns/1ps

module beat_decode (
    input  logic              clk,
    input  logic              rstn,
    input  logic              rs_ena,
    input  logic              data_vld,
    input  logic              data_init,
    input  logic              data_last,
    input  rs_syn_pkg::beat_t syn_data,
    output logic              beat_take,
    output logic              beat_first,
    output logic              beat_last,
    output rs_syn_pkg::beat_t beat_data
);

    logic take;

    // the single point where a beat gets qualified
    assign take = rs_ena & data_vld;

    // marks only carry meaning together with the take pulse
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_take  <= 1'b0;
            beat_first <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            beat_take  <= take;
            beat_first <= take & data_init;
            beat_last  <= take & data_last;
        end
    end

    // symbols held between taken beats
    always_ff @(posedge clk) begin
        if (take) begin
            beat_data <= syn_data;
        end
    end

endmodule

// File: src/rs_syn_pkg.sv
package rs_syn_pkg;

    // input stream word
    localparam int BEAT_W = 64;
    typedef logic [BEAT_W-1:0] beat_t;

    // default syndrome count, four parity symbols
    localparam int DEF_NUM_SYN = 4;

    // one symbol per byte of a beat
    localparam int DEF_SYMS_PER_BEAT = BEAT_W / 8;

endpackage

// File: src/rs_gf_pkg.sv
package rs_gf_pkg;

    // one field element
    localparam int SYM_W = 8;
    typedef logic [SYM_W-1:0] sym_t;

    // x^8 + x^4 + x^3 + x^2 + 1
    localparam logic [SYM_W:0] GF_POLY = 9'h11D;

    // multiplicative group order, alpha^255 = 1
    localparam int GF_ORDER = (1 << SYM_W) - 1;

    // shift-and-add product, reduced by the primitive polynomial
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        sym_t acc;
        sym_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < SYM_W; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            // times x, fold back the overflow bit
            if (sh[SYM_W-1]) begin
                sh = (sh << 1) ^ GF_POLY[SYM_W-1:0];
            end else begin
                sh = sh << 1;
            end
        end
        return acc;
    endfunction

    // alpha^e with alpha = x, only meant for elaboration-time constants
    function automatic sym_t gf_alpha_pow(input int e);
        int   n;
        sym_t p;
        n = e % GF_ORDER;
        if (n < 0) begin
            n = n + GF_ORDER;
        end
        p = sym_t'(1);
        for (int i = 0; i < n; i++) begin
            p = gf_mul(p, sym_t'(2));
        end
        return p;
    endfunction

endpackage
